//--- lane_unit.f
rtl/lane_pkg.sv
rtl/lane_issue_if.sv
rtl/lane_result_if.sv
rtl/lane_regbank.sv
rtl/lane_decode.sv
rtl/lane_execute.sv
rtl/lane_result.sv
rtl/lane_unit.sv
tests/tb_lane_unit.sv

//--- Makefile
# Verilator build and run for the lane testbench

SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_lane_unit
FILELIST = lane_unit.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(wildcard rtl/*.sv tests/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tests/tb_lane_unit.sv
// Directed testbench for the vector lane with register and mask model, checks and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_lane_unit;

	localparam int NUM_CMDS   = 80;		// Commands over all tests
	localparam int TIMEOUT_NS = (NUM_CMDS * 8 + 10) * 10;

	typedef struct packed {
		lane_pkg::reg_idx_t dst;
		lane_pkg::data_t    data;
		logic               written;
		int                 due;		// Negedge count of the commit
	} exp_t;

	logic clock, reset, cmd_valid, cmd_relative, cmd_masked;
	lane_pkg::op_t       cmd_op;
	lane_pkg::reg_idx_t  cmd_dst, cmd_src1, cmd_src2, thread_id, commit_dst;
	lane_pkg::mask_idx_t cmd_mask_sel;
	lane_pkg::data_t     scalar_data, commit_data;
	logic commit, commit_written;

	lane_pkg::data_t regs_m [lane_pkg::NUM_REGS];
	logic [lane_pkg::NUM_MASKS-1:0] mask_m;
	exp_t exp_q [$];
	exp_t head;
	lane_pkg::reg_idx_t tid;
	int neg_count, value_errors, other_errors;
	int seed = 32'hb323;

	lane_unit u_lane_unit (
		.clock(clock), .reset(reset), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
		.cmd_dst(cmd_dst), .cmd_src1(cmd_src1), .cmd_src2(cmd_src2),
		.cmd_relative(cmd_relative), .cmd_masked(cmd_masked),
		.cmd_mask_sel(cmd_mask_sel), .scalar_data(scalar_data), .thread_id(thread_id),
		.commit_dst(commit_dst), .commit_data(commit_data), .commit(commit),
		.commit_written(commit_written)
	);

	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks and model
	////////////////////////////////////////////////////////////////////////////

	task automatic check_data(input string name, input lane_pkg::data_t got, exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_idx(input string name, input lane_pkg::reg_idx_t got, exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic lane_pkg::data_t expected_result(input lane_pkg::op_t op,
		input lane_pkg::data_t a, b);
		case (op)
			lane_pkg::op_add: return a + b;
			lane_pkg::op_sub: return a - b;
			lane_pkg::op_and: return a & b;
			lane_pkg::op_or:  return a | b;
			lane_pkg::op_xor: return a ^ b;
			lane_pkg::op_mul: return a * b;	// Low 32 bits only
			lane_pkg::op_cmp: return lane_pkg::data_t'($signed(a) < $signed(b));
			default:          return a;		// Move returns the scalar
		endcase
	endfunction

	// Commit monitor on the falling edge
	always @(negedge clock) begin
		neg_count = neg_count + 1;
		if (!reset) begin
			if (commit === 1'b1) begin
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("Commit at cycle %0d with no command outstanding", neg_count);
				end else begin
					head = exp_q.pop_front();
					if (neg_count != head.due) begin
						other_errors++;
						$display("Commit at cycle %0d, due at cycle %0d", neg_count, head.due);
					end
					check_idx("commit_dst", commit_dst, head.dst);
					check_data("commit_data", commit_data, head.data);
					check_flag("commit_written", commit_written, head.written);
				end
			end else if (commit !== 1'b0) begin
				other_errors++;
				$display("Commit is unknown at cycle %0d", neg_count);
			end else if (exp_q.size() != 0 && neg_count > exp_q[0].due) begin
				other_errors++;
				$display("Missing commit, due at cycle %0d", exp_q[0].due);
				void'(exp_q.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command driving
	////////////////////////////////////////////////////////////////////////////

	// Drives one command and records what its commit must show
	task automatic send(input lane_pkg::op_t op, input lane_pkg::reg_idx_t dst, src1, src2,
		input logic rel, masked, input lane_pkg::mask_idx_t sel, input lane_pkg::data_t scalar);
		lane_pkg::reg_idx_t off, d, s1, s2;
		lane_pkg::data_t a, r;
		exp_t e;
		off = rel ? tid : 5'd0;
		d = dst + off;
		s1 = src1 + off;
		s2 = src2 + off;
		a = (op == lane_pkg::op_mov) ? scalar : regs_m[s1];
		r = expected_result(op, a, regs_m[s2]);
		if (op == lane_pkg::op_cmp) begin
			mask_m[sel] = r[0];
			e.written = 1'b0;
		end else begin
			e.written = !masked || mask_m[sel];
			if (e.written) regs_m[d] = r;
		end
		e.dst = d;
		e.data = r;
		@(posedge clock);
		cmd_valid    <= 1'b1;
		cmd_op       <= op;
		cmd_dst      <= dst;
		cmd_src1     <= src1;
		cmd_src2     <= src2;
		cmd_relative <= rel;
		cmd_masked   <= masked;
		cmd_mask_sel <= sel;
		scalar_data  <= scalar;
		thread_id    <= tid;
		e.due = neg_count + 5;		// Sampled at the next edge and committed three edges later
		exp_q.push_back(e);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(posedge clock);
		cmd_valid <= 1'b0;
		while (exp_q.size() != 0 && waited < 20) begin
			@(posedge clock);
			waited++;
		end
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("Commits still outstanding after 20 cycles");
			exp_q.delete();
		end
	endtask

	// Register 0 stays zero, so an OR with it returns the register
	task automatic read_back(input lane_pkg::reg_idx_t r);
		send(lane_pkg::op_or, r, r, 5'd0, 1'b0, 1'b0, 3'd0, 32'h0);
		drain();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		repeat (5) @(posedge clock);		// Monitor flags any commit here
		send(lane_pkg::op_mov, 5'd1, 5'd0, 5'd0, 1'b0, 1'b0, 3'd0, 32'h1234_5678);
		drain();
	endtask

	task automatic alu_ops();
		send(lane_pkg::op_mov, 5'd2, 5'd0, 5'd0, 1'b0, 1'b0, 3'd0, 32'h0000_0010);
		send(lane_pkg::op_mov, 5'd3, 5'd0, 5'd0, 1'b0, 1'b0, 3'd0, 32'h8000_0001);
		send(lane_pkg::op_mov, 5'd4, 5'd0, 5'd0, 1'b0, 1'b0, 3'd0, 32'hffff_fff0);
		send(lane_pkg::op_mov, 5'd5, 5'd0, 5'd0, 1'b0, 1'b0, 3'd0, 32'h0000_0003);
		drain();
		send(lane_pkg::op_add, 5'd6, 5'd2, 5'd3, 1'b0, 1'b0, 3'd0, 32'h0);	// Both banks
		drain();
		send(lane_pkg::op_sub, 5'd7, 5'd2, 5'd4, 1'b0, 1'b0, 3'd0, 32'h0);	// Even bank
		drain();
		send(lane_pkg::op_and, 5'd9, 5'd3, 5'd5, 1'b0, 1'b0, 3'd0, 32'h0);	// Odd bank
		drain();
		send(lane_pkg::op_or, 5'd8, 5'd4, 5'd3, 1'b0, 1'b0, 3'd0, 32'h0);
		drain();
		send(lane_pkg::op_xor, 5'd10, 5'd5, 5'd2, 1'b0, 1'b0, 3'd0, 32'h0);
		drain();
		send(lane_pkg::op_mul, 5'd11, 5'd3, 5'd5, 1'b0, 1'b0, 3'd0, 32'h0);
		drain();
		send(lane_pkg::op_cmp, 5'd12, 5'd4, 5'd2, 1'b0, 1'b0, 3'd0, 32'h0);
		drain();
	endtask

	task automatic burst_commits();
		send(lane_pkg::op_mov, 5'd12, 5'd0, 5'd0, 1'b0, 1'b0, 3'd0, 32'haaaa_0001);
		send(lane_pkg::op_mov, 5'd13, 5'd0, 5'd0, 1'b0, 1'b0, 3'd0, 32'hbbbb_0002);
		send(lane_pkg::op_add, 5'd14, 5'd2, 5'd5, 1'b0, 1'b0, 3'd0, 32'h0);
		send(lane_pkg::op_mul, 5'd15, 5'd4, 5'd4, 1'b0, 1'b0, 3'd0, 32'h0);
		send(lane_pkg::op_xor, 5'd16, 5'd3, 5'd9, 1'b0, 1'b0, 3'd0, 32'h0);
		send(lane_pkg::op_sub, 5'd17, 5'd5, 5'd2, 1'b0, 1'b0, 3'd0, 32'h0);
		drain();
	endtask

	task automatic relative_index();
		tid = 5'd5;
		send(lane_pkg::op_mov, 5'd28, 5'd0, 5'd0, 1'b1, 1'b0, 3'd0, 32'hcafe_f00d);
		drain();
		send(lane_pkg::op_add, 5'd26, 5'd28, 5'd29, 1'b1, 1'b0, 3'd0, 32'h0);	// 31 = 1 + 2
		drain();
		read_back(5'd31);
	endtask

	task automatic mask_gating();
		send(lane_pkg::op_cmp, 5'd0, 5'd4, 5'd2, 1'b0, 1'b0, 3'd1, 32'h0);	// Sets entry 1
		send(lane_pkg::op_cmp, 5'd0, 5'd2, 5'd4, 1'b0, 1'b0, 3'd2, 32'h0);	// Clears entry 2
		drain();
		send(lane_pkg::op_mov, 5'd20, 5'd0, 5'd0, 1'b0, 1'b1, 3'd2, 32'hdead_beef);
		drain();
		read_back(5'd20);
		send(lane_pkg::op_mov, 5'd21, 5'd0, 5'd0, 1'b0, 1'b1, 3'd1, 32'h5555_aaaa);
		drain();
		read_back(5'd21);
		send(lane_pkg::op_cmp, 5'd0, 5'd2, 5'd4, 1'b0, 1'b0, 3'd1, 32'h0);
		drain();
		send(lane_pkg::op_add, 5'd21, 5'd2, 5'd3, 1'b0, 1'b1, 3'd1, 32'h0);
		drain();
		read_back(5'd21);
	endtask

	task automatic random_mov_add();
		logic [31:0] rnd;
		lane_pkg::reg_idx_t dst;
		for (int i = 0; i < 50; i++) begin
			rnd = $random(seed);
			dst = rnd[8:4];
			if (dst == 5'd0) dst = 5'd1;		// Keep register 0 at zero
			send(rnd[0] ? lane_pkg::op_add : lane_pkg::op_mov, dst, rnd[13:9], rnd[18:14],
				1'b0, 1'b0, 3'd0, $random(seed));
			drain();
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		clock = 1'b0;
		reset        <= 1'b1;
		cmd_valid    <= 1'b0;
		cmd_op       <= lane_pkg::op_mov;
		cmd_dst      <= '0;
		cmd_src1     <= '0;
		cmd_src2     <= '0;
		cmd_relative <= 1'b0;
		cmd_masked   <= 1'b0;
		cmd_mask_sel <= '0;
		scalar_data  <= '0;
		thread_id    <= '0;
		for (int i = 0; i < lane_pkg::NUM_REGS; i++) regs_m[i] = '0;
		mask_m = '0;
		tid = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		idle_after_reset();
		alu_ops();
		burst_commits();
		relative_index();
		mask_gating();
		random_mov_add();
		repeat (3) @(posedge clock);
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/lane_unit.sv
// Vector lane top with decode, execute and result stages
`timescale 1ns/1ns
`default_nettype none

module lane_unit (
	input  wire logic                 clock,
	input  wire logic                 reset,
	// Command from the scalar unit
	input  wire logic                 cmd_valid,
	input  wire lane_pkg::op_t        cmd_op,
	input  wire lane_pkg::reg_idx_t   cmd_dst,
	input  wire lane_pkg::reg_idx_t   cmd_src1,
	input  wire lane_pkg::reg_idx_t   cmd_src2,
	input  wire logic                 cmd_relative,
	input  wire logic                 cmd_masked,
	input  wire lane_pkg::mask_idx_t  cmd_mask_sel,
	input  wire lane_pkg::data_t      scalar_data,
	input  wire lane_pkg::reg_idx_t   thread_id,
	// Commit report
	output lane_pkg::reg_idx_t        commit_dst,
	output lane_pkg::data_t           commit_data,
	output logic                      commit,
	output logic                      commit_written
);

	// Write-back from the result stage into the banks
	logic               wb_we;
	lane_pkg::reg_idx_t wb_idx;
	lane_pkg::data_t    wb_data;

	lane_issue_if  u_issue ();
	lane_result_if u_result ();

	////////////////////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////////////////////

	lane_decode u_decode (
		.clock        (clock),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_dst      (cmd_dst),
		.cmd_src1     (cmd_src1),
		.cmd_src2     (cmd_src2),
		.cmd_relative (cmd_relative),
		.cmd_masked   (cmd_masked),
		.cmd_mask_sel (cmd_mask_sel),
		.scalar_data  (scalar_data),
		.thread_id    (thread_id),
		.wb_we        (wb_we),
		.wb_idx       (wb_idx),
		.wb_data      (wb_data),
		.issue        (u_issue)
	);

	lane_execute u_execute (
		.clock  (clock),
		.reset  (reset),
		.issue  (u_issue),
		.result (u_result)
	);

	lane_result u_result_stage (
		.clock          (clock),
		.reset          (reset),
		.result         (u_result),
		.wb_we          (wb_we),
		.wb_idx         (wb_idx),
		.wb_data        (wb_data),
		.commit         (commit),
		.commit_dst     (commit_dst),
		.commit_data    (commit_data),
		.commit_written (commit_written)
	);

endmodule

`default_nettype wire

//--- rtl/lane_result.sv
// Mask register, masked write-back and commit outputs
`timescale 1ns/1ns
`default_nettype none

module lane_result (
	input  wire logic           clock,
	input  wire logic           reset,
	lane_result_if.sink         result,
	output logic                wb_we,
	output lane_pkg::reg_idx_t  wb_idx,
	output lane_pkg::data_t     wb_data,
	output logic                commit,
	output lane_pkg::reg_idx_t  commit_dst,
	output lane_pkg::data_t     commit_data,
	output logic                commit_written
);

	logic [lane_pkg::NUM_MASKS-1:0] mask_q;
	logic is_cmp;
	logic enabled;		// Mask lets the write through

	assign is_cmp  = (result.op == lane_pkg::op_cmp);
	assign enabled = ~result.masked | mask_q[result.mask_sel];

	// Compares never touch the register file
	assign wb_we   = result.valid & ~is_cmp & enabled;
	assign wb_idx  = result.dst;
	assign wb_data = result.data;

	////////////////////////////////////////////////////////////////////////////
	// Mask entries
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			mask_q <= '0;
		end else if (result.valid && is_cmp) begin
			mask_q[result.mask_sel] <= result.data[0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Commit, same edge as the bank write
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commit         <= 1'b0;
			commit_written <= 1'b0;
		end else begin
			commit         <= result.valid;
			commit_written <= wb_we;
		end
	end

	always_ff @(posedge clock) begin
		if (result.valid) begin
			commit_dst  <= result.dst;
			commit_data <= result.data;
		end
	end

endmodule

`default_nettype wire

//--- rtl/lane_execute.sv
// Arithmetic, logic, move and compare unit with registered result
`timescale 1ns/1ns
`default_nettype none

module lane_execute (
	input  wire logic    clock,
	input  wire logic    reset,
	lane_issue_if.sink   issue,
	lane_result_if.source result
);

	lane_pkg::data_t alu_out;
	logic            less;		// Signed compare

	assign less = $signed(issue.src_a) < $signed(issue.src_b);

	////////////////////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		alu_out = '0;
		case (issue.op)
			lane_pkg::op_mov: alu_out = issue.src_a;	// Scalar from decode
			lane_pkg::op_add: alu_out = issue.src_a + issue.src_b;
			lane_pkg::op_sub: alu_out = issue.src_a - issue.src_b;
			lane_pkg::op_and: alu_out = issue.src_a & issue.src_b;
			lane_pkg::op_or:  alu_out = issue.src_a | issue.src_b;
			lane_pkg::op_xor: alu_out = issue.src_a ^ issue.src_b;
			// Product truncated to the word width
			lane_pkg::op_mul: alu_out = issue.src_a * issue.src_b;
			lane_pkg::op_cmp: alu_out = lane_pkg::data_t'(less);
			default:          alu_out = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Result register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) result.valid <= 1'b0;
		else        result.valid <= issue.valid;
	end

	always_ff @(posedge clock) begin
		if (issue.valid) begin
			result.op       <= issue.op;
			result.dst      <= issue.dst;
			result.data     <= alu_out;
			result.masked   <= issue.masked;
			result.mask_sel <= issue.mask_sel;
		end
	end

endmodule

`default_nettype wire

//--- rtl/lane_decode.sv
// Command capture, thread-relative indexing, bank read and operand steering
`timescale 1ns/1ns
`default_nettype none

module lane_decode (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 cmd_valid,
	input  wire lane_pkg::op_t        cmd_op,
	input  wire lane_pkg::reg_idx_t   cmd_dst,
	input  wire lane_pkg::reg_idx_t   cmd_src1,
	input  wire lane_pkg::reg_idx_t   cmd_src2,
	input  wire logic                 cmd_relative,
	input  wire logic                 cmd_masked,
	input  wire lane_pkg::mask_idx_t  cmd_mask_sel,
	input  wire lane_pkg::data_t      scalar_data,
	input  wire lane_pkg::reg_idx_t   thread_id,
	input  wire logic                 wb_we,
	input  wire lane_pkg::reg_idx_t   wb_idx,
	input  wire lane_pkg::data_t      wb_data,
	lane_issue_if.source              issue
);

	////////////////////////////////////////////////////////////////////////////
	// Capture stage
	////////////////////////////////////////////////////////////////////////////

	lane_pkg::reg_idx_t  offset;		// Thread offset or zero
	logic                s1_valid;
	lane_pkg::op_t       s1_op;
	lane_pkg::reg_idx_t  s1_dst, s1_src1, s1_src2;
	lane_pkg::data_t     s1_scalar;
	logic                s1_masked;
	lane_pkg::mask_idx_t s1_mask_sel;

	assign offset = cmd_relative ? thread_id : '0;

	always_ff @(posedge clock) begin
		if (reset) s1_valid <= 1'b0;
		else        s1_valid <= cmd_valid;
	end

	// Index sums wrap modulo 32
	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			s1_op       <= cmd_op;
			s1_dst      <= cmd_dst + offset;
			s1_src1     <= cmd_src1 + offset;
			s1_src2     <= cmd_src2 + offset;
			s1_scalar   <= scalar_data;
			s1_masked   <= cmd_masked;
			s1_mask_sel <= cmd_mask_sel;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Register read stage
	////////////////////////////////////////////////////////////////////////////

	lane_pkg::data_t even_a, even_b, odd_a, odd_b;
	lane_pkg::data_t s2_scalar;
	logic            s2_src1_odd, s2_src2_odd;

	// Source 1 on port a and source 2 on port b of both banks
	lane_regbank bank_even (
		.clock(clock), .reset(reset),
		.we(wb_we & ~wb_idx[0]), .wr_idx(wb_idx[4:1]), .wr_data(wb_data),
		.rd_idx_a(s1_src1[4:1]), .rd_idx_b(s1_src2[4:1]),
		.rd_data_a(even_a), .rd_data_b(even_b)
	);

	lane_regbank bank_odd (
		.clock(clock), .reset(reset),
		.we(wb_we & wb_idx[0]), .wr_idx(wb_idx[4:1]), .wr_data(wb_data),
		.rd_idx_a(s1_src1[4:1]), .rd_idx_b(s1_src2[4:1]),
		.rd_data_a(odd_a), .rd_data_b(odd_b)
	);

	always_ff @(posedge clock) begin
		if (reset) issue.valid <= 1'b0;
		else        issue.valid <= s1_valid;
	end

	always_ff @(posedge clock) begin
		if (s1_valid) begin
			issue.op       <= s1_op;
			issue.dst      <= s1_dst;
			issue.masked   <= s1_masked;
			issue.mask_sel <= s1_mask_sel;
			s2_scalar      <= s1_scalar;
			s2_src1_odd    <= s1_src1[0];	// Bank of each source
			s2_src2_odd    <= s1_src2[0];
		end
	end

	// Steer bank data, scalar replaces source 1 for moves
	assign issue.src_a = (issue.op == lane_pkg::op_mov) ? s2_scalar
		: (s2_src1_odd ? odd_a : even_a);
	assign issue.src_b = s2_src2_odd ? odd_b : even_b;

endmodule

`default_nettype wire

//--- rtl/lane_regbank.sv
// Register bank with two registered read ports and one write port
`timescale 1ns/1ns
`default_nettype none

module lane_regbank (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 we,
	input  wire lane_pkg::bank_idx_t  wr_idx,
	input  wire lane_pkg::data_t      wr_data,
	input  wire lane_pkg::bank_idx_t  rd_idx_a,
	input  wire lane_pkg::bank_idx_t  rd_idx_b,
	output lane_pkg::data_t           rd_data_a,
	output lane_pkg::data_t           rd_data_b
);

	lane_pkg::data_t mem [lane_pkg::BANK_DEPTH];

	// Storage, cleared so register 0 reads zero after reset
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < lane_pkg::BANK_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_idx] <= wr_data;
		end
	end

	// Read ports return the old value on a same-edge write
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_data_a <= '0;
			rd_data_b <= '0;
		end else begin
			rd_data_a <= mem[rd_idx_a];
			rd_data_b <= mem[rd_idx_b];
		end
	end

endmodule

`default_nettype wire

//--- rtl/lane_result_if.sv
// Executed result, execute to result stage
`timescale 1ns/1ns
`default_nettype none

interface lane_result_if;

	logic                valid;
	lane_pkg::op_t       op;		// Needed to tell compares apart
	lane_pkg::reg_idx_t  dst;
	lane_pkg::data_t     data;
	logic                masked;
	lane_pkg::mask_idx_t mask_sel;

	// Execute side
	modport source (
		output valid, op, dst, data, masked, mask_sel
	);

	// Result stage side
	modport sink (
		input valid, op, dst, data, masked, mask_sel
	);

endinterface

`default_nettype wire

//--- rtl/lane_issue_if.sv
// Decoded command with operand data, decode to execute
`timescale 1ns/1ns
`default_nettype none

interface lane_issue_if;

	logic                valid;		// One command per cycle
	lane_pkg::op_t       op;
	lane_pkg::reg_idx_t  dst;		// Resolved destination
	lane_pkg::data_t     src_a;		// Scalar for op_mov
	lane_pkg::data_t     src_b;
	logic                masked;
	lane_pkg::mask_idx_t mask_sel;

	// Decode side
	modport source (
		output valid, op, dst, src_a, src_b, masked, mask_sel
	);

	// Execute side
	modport sink (
		input valid, op, dst, src_a, src_b, masked, mask_sel
	);

endinterface

`default_nettype wire

//--- rtl/lane_pkg.sv
// Lane sizes, data and index types, and the operation encoding
`default_nettype none

package lane_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH = 32;		// Lane data word
	localparam int NUM_REGS   = 32;		// Registers over both banks
	localparam int BANK_DEPTH = 16;		// Entries per bank
	localparam int NUM_MASKS  = 8;		// One-bit mask entries

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	// Lane data word
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Register index, bit 0 picks the bank and the upper bits the entry
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

	// Entry inside one bank
	typedef logic [$clog2(BANK_DEPTH)-1:0] bank_idx_t;

	// Mask entry number
	typedef logic [$clog2(NUM_MASKS)-1:0] mask_idx_t;

	// Lane operations
	typedef enum logic [2:0] {
		op_mov = 3'd0,		// Scalar operand
		op_add = 3'd1,
		op_sub = 3'd2,
		op_and = 3'd3,
		op_or  = 3'd4,
		op_xor = 3'd5,
		op_mul = 3'd6,		// Low half of unsigned product
		op_cmp = 3'd7		// Signed less-than into a mask entry
	} op_t;

endpackage

`default_nettype wire
